// ==== files.f ====
logic/dcache_pkg.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_age.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/dcache_props.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module dcache_tb -f files.f \
    --Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== dv/dcache_tb.sv ====
// testbench for the two-way data cache, seeded random requests over 4 tags x 4 sets
// the wishbone memory returns each word's own address until it is written
// ack comes 0 to 3 cycles after stb; all comparing is done in dcache_checker
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int SET_BITS       = DEFAULT_SET_BITS;
    localparam int NUM_TESTS      = 3;
    localparam int REQS_PER_TEST  = 300;
    localparam int XFER_MAX       = 5;
    localparam int CYCLES_PER_REQ = 2 + 2 * XFER_MAX + 4;
    localparam int CYCLE_LIMIT    = NUM_TESTS * REQS_PER_TEST * CYCLES_PER_REQ * 2;
    localparam logic [TAG_W-1:0] TAG_BASE = TAG_W'(32'h2a000);

    logic              clk;
    logic              reset;
    logic              req_valid;
    logic              req_ready;
    logic              resp_valid;
    cpu_req_t          req;
    cpu_resp_t         resp;
    wb_m2s_t           wb_m;
    wb_s2m_t           wb_s;
    int                chk_errors;
    int                chk_responses;
    int                cycles;
    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];

    string test_names [NUM_TESTS] = '{"mixed", "write_heavy", "read_heavy"};
    int    write_pct  [NUM_TESTS] = '{50, 80, 20};

    dcache_top #(.SET_BITS(SET_BITS)) u_dut (
        .clk(clk), .reset_i(reset), .req_valid_i(req_valid), .req_i(req),
        .req_ready_o(req_ready), .resp_valid_o(resp_valid), .resp_o(resp),
        .wb_o(wb_m), .wb_i(wb_s)
    );

    dcache_checker u_chk (
        .clk(clk), .reset_i(reset), .req_valid_i(req_valid), .req_i(req),
        .req_ready_o(req_ready), .resp_valid_o(resp_valid), .resp_o(resp),
        .wb_o(wb_m), .wb_i(wb_s), .errors_o(chk_errors), .responses_o(chk_responses)
    );

    bind dcache_top dcache_props u_props (
        .clk(clk), .reset_i(reset_i), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
        .resp_valid_o(resp_valid_o), .wb_o(wb_o), .wb_i(wb_i)
    );

    function automatic logic [DATA_W-1:0] load_word(input logic [ADDR_W-1:0] adr);
        if (mem.exists(adr)) begin
            return mem[adr];
        end
        return DATA_W'(adr);
    endfunction

    function automatic void store_word(input logic [ADDR_W-1:0] adr,
                                       input logic [DATA_W-1:0] dat,
                                       input logic [STRB_W-1:0] sel);
        logic [DATA_W-1:0] w;
        w = load_word(adr);
        for (int b = 0; b < STRB_W; b++) begin
            if (sel[b]) begin
                w[b*8 +: 8] = dat[b*8 +: 8];
            end
        end
        mem[adr] = w;
    endfunction

    // few tags on few sets, so lines conflict and get evicted
    function automatic logic [ADDR_W-1:0] pick_address();
        logic [TAG_W-1:0]    tag;
        logic [SET_BITS-1:0] set_idx;
        tag     = TAG_BASE + TAG_W'($urandom % 4);
        set_idx = SET_BITS'(($urandom % 4) * 16 + 1);
        return {tag, set_idx, {OFFSET_W{1'b0}}};
    endfunction

    task automatic issue_request(input int pct);
        cpu_req_t r;
        r.addr  = pick_address();
        r.we    = ($urandom % 100) < pct;
        r.wdata = {$urandom, $urandom};
        r.strb  = STRB_W'($urandom);
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        #1 req_valid = 1'b0;
        @(posedge clk);
        while (!resp_valid) @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // wishbone memory, one transfer per cycle
    initial begin : wb_memory
        int                wait_left;
        bit                busy;
        logic [DATA_W-1:0] rd;
        wb_s      = '0;
        busy      = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            if (reset || wb_s.ack) begin
                #1 wb_s.ack = 1'b0;
                busy = 1'b0;
            end else if (wb_m.cyc && wb_m.stb) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = int'($urandom % 4);
                end
                if (wait_left == 0) begin
                    rd = load_word(wb_m.adr);
                    if (wb_m.we) begin
                        store_word(wb_m.adr, wb_m.dat, wb_m.sel);
                    end
                    #1;
                    wb_s.dat = rd;
                    wb_s.ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: requests still pending after %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        int seed_ret;
        int errors_before;
        seed_ret  = $urandom(22);
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errors_before = chk_errors;
            repeat (REQS_PER_TEST) issue_request(write_pct[t]);
            $display("test %0d %s: %0d requests, %0d errors", t, test_names[t],
                     REQS_PER_TEST, chk_errors - errors_before);
        end
        $display("%0d tests, %0d responses checked, %0d errors", NUM_TESTS, chk_responses,
                 chk_errors);
        if (chk_errors == 0 && chk_responses == NUM_TESTS * REQS_PER_TEST) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dv/dcache_checker.sv ====
// reference model of the cache: valid, dirty, tag and age per set and way
// plus the word values the cpu must see; assumes the default 6 set bits
// compares every response and every completed wishbone transfer
`timescale 1ns/1ps

module dcache_checker (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  req_valid_i,
    input  dcache_pkg::cpu_req_t  req_i,
    input  logic                  req_ready_o,
    input  logic                  resp_valid_o,
    input  dcache_pkg::cpu_resp_t resp_o,
    input  dcache_pkg::wb_m2s_t   wb_o,
    input  dcache_pkg::wb_s2m_t   wb_i,
    output int                    errors_o,
    output int                    responses_o
);
    import dcache_pkg::*;

    localparam int SET_BITS  = 6;
    localparam int NUM_SETS  = 1 << SET_BITS;
    localparam int AGE_LIMIT = 7;

    bit                m_valid [NUM_SETS][NUM_WAYS];
    bit                m_dirty [NUM_SETS][NUM_WAYS];
    bit [TAG_W-1:0]    m_tag   [NUM_SETS][NUM_WAYS];
    int                m_age   [NUM_SETS][NUM_WAYS];
    bit [DATA_W-1:0]   arch_mem [bit [ADDR_W-1:0]];
    bit                pending;
    bit                check_reset;
    bit                exp_hit;
    bit                exp_wb;
    bit [ADDR_W-1:0]   wb_addr;
    bit [ADDR_W-1:0]   rd_addr;
    bit [DATA_W-1:0]   wb_data;
    bit [DATA_W-1:0]   exp_rdata;
    int                cycle;
    int                accept_cycle;
    int                xfers;

    // untouched words hold their own address
    function automatic bit [DATA_W-1:0] arch_read(input bit [ADDR_W-1:0] a);
        if (arch_mem.exists(a)) begin
            return arch_mem[a];
        end
        return DATA_W'(a);
    endfunction

    function automatic void merge_write(input bit [ADDR_W-1:0] a, input bit [DATA_W-1:0] d,
                                        input bit [STRB_W-1:0] s);
        bit [DATA_W-1:0] w;
        w = arch_read(a);
        for (int b = 0; b < STRB_W; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        arch_mem[a] = w;
    endfunction

    task automatic flag_error(input string msg);
        $display("%s", msg);
        errors_o++;
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            errors_o++;
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end
    endtask

    // whole outcome of one request, including the hit that ends a miss
    task automatic predict(input cpu_req_t r);
        bit [SET_BITS-1:0] idx;
        bit [TAG_W-1:0]    tg;
        int                hw;
        int                vw;
        idx     = r.addr[OFFSET_W +: SET_BITS];
        tg      = r.addr[ADDR_W-1 -: TAG_W];
        rd_addr = {r.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        hw      = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                hw = w;
            end
        end
        exp_hit = (hw >= 0);
        exp_wb  = 1'b0;
        if (!exp_hit) begin
            if (!m_valid[idx][0]) begin
                vw = 0;
            end else if (!m_valid[idx][1]) begin
                vw = 1;
            end else begin
                vw = (m_age[idx][1] > m_age[idx][0]) ? 1 : 0;
            end
            exp_wb  = m_valid[idx][vw] && m_dirty[idx][vw];
            wb_addr = {m_tag[idx][vw], idx, {OFFSET_W{1'b0}}};
            wb_data = arch_read(wb_addr);
            m_valid[idx][vw] = 1'b1;
            m_dirty[idx][vw] = 1'b0;
            m_tag[idx][vw]   = tg;
            hw = vw;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w == hw) begin
                m_age[idx][w] = 0;
            end else if (m_age[idx][w] < AGE_LIMIT) begin
                m_age[idx][w]++;
            end
        end
        if (r.we) begin
            m_dirty[idx][hw] = 1'b1;
            merge_write(rd_addr, r.wdata, r.strb);
            exp_rdata = '0;
        end else begin
            exp_rdata = arch_read(rd_addr);
        end
    endtask

    task automatic check_transfer();
        if (!pending) begin
            flag_error("wishbone transfer with no request in flight");
        end else if (exp_hit) begin
            flag_error("wishbone transfer on a request that should hit");
        end else if (exp_wb && xfers == 0) begin
            check_value("wb_o.we", DATA_W'(wb_o.we), DATA_W'(1));
            check_value("wb_o.adr", DATA_W'(wb_o.adr), DATA_W'(wb_addr));
            check_value("wb_o.dat", wb_o.dat, wb_data);
            check_value("wb_o.sel", DATA_W'(wb_o.sel), DATA_W'(8'hff));
        end else if (xfers == (exp_wb ? 1 : 0)) begin
            check_value("wb_o.we", DATA_W'(wb_o.we), DATA_W'(0));
            check_value("wb_o.adr", DATA_W'(wb_o.adr), DATA_W'(rd_addr));
        end else begin
            flag_error("more wishbone transfers than the miss needs");
        end
        xfers++;
    endtask

    task automatic check_response();
        int exp_xfers;
        exp_xfers = exp_hit ? 0 : (exp_wb ? 2 : 1);
        if (!pending) begin
            flag_error("response with no request in flight");
        end else begin
            check_value("resp_o.rdata", resp_o.rdata, exp_rdata);
            if (exp_hit && cycle != accept_cycle + 2) begin
                flag_error($sformatf("hit answered after %0d cycles instead of 2",
                                     cycle - accept_cycle));
            end
            if (xfers != exp_xfers) begin
                flag_error($sformatf("response after %0d wishbone transfers, expected %0d",
                                     xfers, exp_xfers));
            end
            pending = 1'b0;
            responses_o++;
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (reset_i) begin
            clear_model();
            pending     = 1'b0;
            check_reset = 1'b1;
        end else begin
            if (check_reset) begin
                check_value("req_ready_o", DATA_W'(req_ready_o), DATA_W'(1));
                check_value("wb_o.cyc", DATA_W'(wb_o.cyc), DATA_W'(0));
                check_value("resp_valid_o", DATA_W'(resp_valid_o), DATA_W'(0));
                check_reset = 1'b0;
            end
            if (wb_o.cyc && wb_o.stb && wb_i.ack) begin
                check_transfer();
            end
            if (resp_valid_o) begin
                check_response();
            end
            if (req_valid_i && req_ready_o) begin
                predict(req_i);
                pending      = 1'b1;
                accept_cycle = cycle;
                xfers        = 0;
            end
        end
    end

endmodule

// ==== dv/dcache_props.sv ====
// handshake assertions for the cache top level, attached to dcache_top with bind
// wishbone checks cover the classic single-transfer cycle only
`timescale 1ns/1ps

module dcache_props (
    input logic                clk,
    input logic                reset_i,
    input logic                req_valid_i,
    input logic                req_ready_o,
    input logic                resp_valid_o,
    input dcache_pkg::wb_m2s_t wb_o,
    input dcache_pkg::wb_s2m_t wb_i
);
    logic busy_q;

    // a request is in flight from its accept edge up to its response
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
        end else if (resp_valid_o) begin
            busy_q <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            busy_q <= 1'b1;
        end
    end

    // cycle ends on ack and stays idle for at least one clock
    cyc_drops_after_ack: assert property (@(posedge clk) disable iff (reset_i)
        (wb_o.cyc && wb_o.stb && wb_i.ack) |=> (!wb_o.cyc && !wb_o.stb))
        else $error("wishbone cycle not dropped after ack");

    bus_held: assert property (@(posedge clk) disable iff (reset_i)
        (wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.we)
                                     && $stable(wb_o.dat) && $stable(wb_o.sel)))
        else $error("wishbone request changed before ack");

    resp_single: assert property (@(posedge clk) disable iff (reset_i)
        resp_valid_o |=> !resp_valid_o)
        else $error("response valid on two cycles in a row");

    ready_low_busy: assert property (@(posedge clk) disable iff (reset_i)
        busy_q |-> !req_ready_o)
        else $error("request ready while a request is in flight");

endmodule

// ==== logic/dcache_top.sv ====
// two-way write-back data cache, cpu valid/ready port in, wishbone classic out
// one request in flight; the cpu response has no back-pressure
// SET_BITS sets the number of sets and must be 6 or more
`timescale 1ns/1ps

module dcache_top #(
    parameter int SET_BITS = dcache_pkg::DEFAULT_SET_BITS
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  req_valid_i,
    input  dcache_pkg::cpu_req_t  req_i,
    output logic                  req_ready_o,
    output logic                  resp_valid_o,
    output dcache_pkg::cpu_resp_t resp_o,
    output dcache_pkg::wb_m2s_t   wb_o,
    input  dcache_pkg::wb_s2m_t   wb_i
);
    import dcache_pkg::*;

    logic [SET_BITS-1:0]                index;
    logic [NUM_WAYS-1:0]                tag_wr_en;
    tag_entry_t                         tag_wr_entry;
    tag_entry_t [NUM_WAYS-1:0]          tag_entries;
    logic [NUM_WAYS-1:0][DATA_W-1:0]    data_words;
    logic [WAY_W-1:0]                   data_wr_way;
    logic                               data_wr_en;
    logic [STRB_W-1:0]                  data_wr_strb;
    logic [DATA_W-1:0]                  data_wr_data;
    logic                               touch;
    logic [WAY_W-1:0]                   touch_way, victim_way;
    logic [NUM_WAYS-1:0]                way_valid;

    assign way_valid = {tag_entries[1].valid, tag_entries[0].valid};

    dcache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (
        .clk, .reset_i, .req_valid_i, .req_i, .req_ready_o, .resp_valid_o, .resp_o,
        .index_o(index), .tag_entries_i(tag_entries), .tag_wr_en_o(tag_wr_en),
        .tag_wr_entry_o(tag_wr_entry), .data_words_i(data_words),
        .data_wr_way_o(data_wr_way), .data_wr_en_o(data_wr_en),
        .data_wr_strb_o(data_wr_strb), .data_wr_data_o(data_wr_data),
        .victim_way_i(victim_way), .touch_o(touch), .touch_way_o(touch_way),
        .wb_o, .wb_i
    );

    dcache_tag_array #(.SET_BITS(SET_BITS)) u_tags (
        .clk, .reset_i, .rd_index_i(index), .wr_en_i(tag_wr_en),
        .wr_index_i(index), .wr_entry_i(tag_wr_entry), .rd_entries_o(tag_entries)
    );

    dcache_data_array #(.SET_BITS(SET_BITS)) u_data (
        .clk, .index_i(index), .wr_way_i(data_wr_way), .wr_en_i(data_wr_en),
        .wr_strb_i(data_wr_strb), .wr_data_i(data_wr_data), .rd_data_o(data_words)
    );

    dcache_age #(.SET_BITS(SET_BITS)) u_age (
        .clk, .reset_i, .index_i(index), .touch_i(touch), .touch_way_i(touch_way),
        .valid_i(way_valid), .victim_way_o(victim_way)
    );

endmodule

// ==== logic/dcache_ctrl.sv ====
// single-request cache controller and wishbone classic master
// hit: lookup cycle then compare cycle, response comes with the compare
// miss: optional victim write-back, word read, fill, then a fresh lookup
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int SET_BITS = dcache_pkg::DEFAULT_SET_BITS
) (
    input  logic                                                   clk,
    input  logic                                                   reset_i,
    input  logic                                                   req_valid_i,
    input  dcache_pkg::cpu_req_t                                   req_i,
    output logic                                                   req_ready_o,
    output logic                                                   resp_valid_o,
    output dcache_pkg::cpu_resp_t                                  resp_o,
    output logic [SET_BITS-1:0]                                    index_o,
    input  dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0]      tag_entries_i,
    output logic [dcache_pkg::NUM_WAYS-1:0]                        tag_wr_en_o,
    output dcache_pkg::tag_entry_t                                 tag_wr_entry_o,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::DATA_W-1:0] data_words_i,
    output logic [dcache_pkg::WAY_W-1:0]                           data_wr_way_o,
    output logic                                                   data_wr_en_o,
    output logic [dcache_pkg::STRB_W-1:0]                          data_wr_strb_o,
    output logic [dcache_pkg::DATA_W-1:0]                          data_wr_data_o,
    input  logic [dcache_pkg::WAY_W-1:0]                           victim_way_i,
    output logic                                                   touch_o,
    output logic [dcache_pkg::WAY_W-1:0]                           touch_way_o,
    output dcache_pkg::wb_m2s_t                                    wb_o,
    input  dcache_pkg::wb_s2m_t                                    wb_i
);
    import dcache_pkg::*;

    localparam int REQ_TAG_W = ADDR_W - OFFSET_W - SET_BITS;

    typedef enum logic [2:0] {
        S_IDLE, S_LOOKUP, S_COMPARE, S_WB, S_FILL_RD, S_FILL
    } state_e;

    state_e                state_q, state_d;
    cpu_req_t              req_q;
    logic [WAY_W-1:0]      victim_q;
    logic [DATA_W-1:0]     fill_data_q;
    logic                  bus_cyc_q, bus_we_q;
    logic [ADDR_W-1:0]     bus_adr_q;
    logic [DATA_W-1:0]     bus_dat_q;
    logic [REQ_TAG_W-1:0]  req_tag, victim_tag;
    logic [NUM_WAYS-1:0]   way_hit;
    logic                  hit, accept, victim_dirty, bus_done, write_hit;
    logic [WAY_W-1:0]      hit_way;

    assign req_tag      = req_q.addr[ADDR_W-1 -: REQ_TAG_W];
    assign index_o      = req_q.addr[OFFSET_W +: SET_BITS];
    assign req_ready_o  = (state_q == S_IDLE);
    assign accept       = req_valid_i && req_ready_o;
    assign bus_done     = bus_cyc_q && wb_i.ack;
    assign victim_tag   = tag_entries_i[victim_way_i].tag[REQ_TAG_W-1:0];
    assign victim_dirty = tag_entries_i[victim_way_i].valid && tag_entries_i[victim_way_i].dirty;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = tag_entries_i[w].valid &&
                         (tag_entries_i[w].tag[REQ_TAG_W-1:0] == req_tag);
        end
    end

    assign hit       = |way_hit;
    assign hit_way   = WAY_W'(way_hit[1]);
    assign write_hit = (state_q == S_COMPARE) && hit && req_q.we;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:    if (accept) state_d = S_LOOKUP;
            S_LOOKUP:  state_d = S_COMPARE;
            S_COMPARE: state_d = hit ? S_IDLE : (victim_dirty ? S_WB : S_FILL_RD);
            S_WB:      if (bus_done) state_d = S_FILL_RD;
            S_FILL_RD: if (bus_done) state_d = S_FILL;
            S_FILL:    state_d = S_LOOKUP;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= S_IDLE;
            bus_cyc_q <= 1'b0;
            bus_we_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (bus_done) begin
                bus_cyc_q <= 1'b0;
            end else if (state_q == S_COMPARE && !hit) begin
                bus_cyc_q <= 1'b1;
                bus_we_q  <= victim_dirty;
            end else if (state_q == S_FILL_RD && !bus_cyc_q) begin
                // read starts one idle cycle after the write-back ends
                bus_cyc_q <= 1'b1;
                bus_we_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (state_q == S_COMPARE) begin
            victim_q  <= victim_way_i;
            bus_dat_q <= data_words_i[victim_way_i];
            bus_adr_q <= victim_dirty ? {victim_tag, index_o, {OFFSET_W{1'b0}}}
                                      : {req_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end else if (state_q == S_FILL_RD && !bus_cyc_q) begin
            bus_adr_q <= {req_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
        if (bus_done && !bus_we_q) begin
            fill_data_q <= wb_i.dat;
        end
    end

    assign resp_valid_o = (state_q == S_COMPARE) && hit;
    assign resp_o.rdata = (resp_valid_o && !req_q.we) ? data_words_i[hit_way] : '0;
    assign touch_o      = resp_valid_o;
    assign touch_way_o  = hit_way;

    // write hit merges strobed bytes, fill installs the whole word
    assign data_wr_en_o   = write_hit || (state_q == S_FILL);
    assign data_wr_way_o  = (state_q == S_FILL) ? victim_q : hit_way;
    assign data_wr_strb_o = (state_q == S_FILL) ? '1 : req_q.strb;
    assign data_wr_data_o = (state_q == S_FILL) ? fill_data_q : req_q.wdata;

    always_comb begin
        tag_wr_en_o = '0;
        if (write_hit) begin
            tag_wr_en_o[hit_way] = 1'b1;
        end else if (state_q == S_FILL) begin
            tag_wr_en_o[victim_q] = 1'b1;
        end
        tag_wr_entry_o       = '0;
        tag_wr_entry_o.valid = 1'b1;
        tag_wr_entry_o.dirty = (state_q != S_FILL);
        tag_wr_entry_o.tag[REQ_TAG_W-1:0] = req_tag;
    end

    always_comb begin
        wb_o.cyc = bus_cyc_q;
        wb_o.stb = bus_cyc_q;
        wb_o.we  = bus_we_q;
        wb_o.adr = bus_adr_q;
        wb_o.dat = bus_dat_q;
        wb_o.sel = '1;
    end

endmodule

// ==== logic/dcache_age.sv ====
// per-set age counters for both ways, and victim choice
// ages move only on a completed hit; victim is combinational from the stored ages
`timescale 1ns/1ps

module dcache_age #(
    parameter int SET_BITS = dcache_pkg::DEFAULT_SET_BITS
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [SET_BITS-1:0]             index_i,
    input  logic                            touch_i,
    input  logic [dcache_pkg::WAY_W-1:0]    touch_way_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0] valid_i,
    output logic [dcache_pkg::WAY_W-1:0]    victim_way_o
);
    import dcache_pkg::*;

    localparam int NUM_SETS = 1 << SET_BITS;

    logic [AGE_W-1:0] age_q [NUM_SETS][NUM_WAYS];
    logic [AGE_W-1:0] age0;
    logic [AGE_W-1:0] age1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_q[s][w] <= AGE_INIT;
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (WAY_W'(w) == touch_way_i) begin
                    age_q[index_i][w] <= AGE_INIT;
                end else if (age_q[index_i][w] != AGE_MAX) begin
                    age_q[index_i][w] <= age_q[index_i][w] + AGE_W'(1);
                end
            end
        end
    end

    assign age0 = age_q[index_i][0];
    assign age1 = age_q[index_i][1];

    // empty ways first, then the older way
    always_comb begin
        if (!valid_i[0]) begin
            victim_way_o = WAY_W'(0);
        end else if (!valid_i[1]) begin
            victim_way_o = WAY_W'(1);
        end else if (age0 == age1) begin
            victim_way_o = VICTIM_TIE_WAY;
        end else begin
            victim_way_o = (age1 > age0) ? WAY_W'(1) : WAY_W'(0);
        end
    end

endmodule

// ==== logic/dcache_data_array.sv ====
// word store for both ways, one 64-bit word per line
// read returns both ways one cycle after index_i; read and write share the index
// a write touches only the strobed bytes of the chosen way
`timescale 1ns/1ps

module dcache_data_array #(
    parameter int SET_BITS = dcache_pkg::DEFAULT_SET_BITS
) (
    input  logic                                                   clk,
    input  logic [SET_BITS-1:0]                                    index_i,
    input  logic [dcache_pkg::WAY_W-1:0]                           wr_way_i,
    input  logic                                                   wr_en_i,
    input  logic [dcache_pkg::STRB_W-1:0]                          wr_strb_i,
    input  logic [dcache_pkg::DATA_W-1:0]                          wr_data_i,
    output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::DATA_W-1:0] rd_data_o
);
    import dcache_pkg::*;

    localparam int NUM_SETS = 1 << SET_BITS;

    logic [DATA_W-1:0] mem_q [NUM_WAYS][NUM_SETS];

    // byte-lane writes
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_strb_i[b]) begin
                    mem_q[wr_way_i][index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_data_o[w] <= mem_q[w][index_i];
        end
    end

endmodule

// ==== logic/dcache_tag_array.sv ====
// valid, dirty and tag store for both ways of every set
// read data appears one cycle after rd_index_i; a write replaces the whole entry
// read during a write to the same set returns the old entry
`timescale 1ns/1ps

module dcache_tag_array #(
    parameter int SET_BITS = dcache_pkg::DEFAULT_SET_BITS
) (
    input  logic                                             clk,
    input  logic                                             reset_i,
    input  logic [SET_BITS-1:0]                              rd_index_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                  wr_en_i,
    input  logic [SET_BITS-1:0]                              wr_index_i,
    input  dcache_pkg::tag_entry_t                           wr_entry_i,
    output dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] rd_entries_o
);
    import dcache_pkg::*;

    localparam int NUM_SETS = 1 << SET_BITS;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
    logic [TAG_W-1:0]    tag_q   [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] rd_valid_q;
    logic [NUM_WAYS-1:0] rd_dirty_q;
    logic [TAG_W-1:0]    rd_tag_q [NUM_WAYS];

    // state bits, cleared so every line starts invalid
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            rd_valid_q <= '0;
            rd_dirty_q <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (wr_en_i[w]) begin
                    valid_q[wr_index_i][w] <= wr_entry_i.valid;
                    dirty_q[wr_index_i][w] <= wr_entry_i.dirty;
                end
            end
            rd_valid_q <= valid_q[rd_index_i];
            rd_dirty_q <= dirty_q[rd_index_i];
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr_en_i[w]) begin
                tag_q[w][wr_index_i] <= wr_entry_i.tag;
            end
            rd_tag_q[w] <= tag_q[w][rd_index_i];
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_entries_o[w].valid = rd_valid_q[w];
            rd_entries_o[w].dirty = rd_dirty_q[w];
            rd_entries_o[w].tag   = rd_tag_q[w];
        end
    end

endmodule

// ==== logic/dcache_pkg.sv ====
// shared widths, bus and request types for the two-way data cache
// tag_entry_t holds a tag for 6 set bits; larger SET_BITS leave upper tag bits zero,
// so SET_BITS must be 6 or more
// accesses are word aligned, the low offset bits are ignored

package dcache_pkg;

    localparam int ADDR_W           = 32;
    localparam int DATA_W           = 64;
    localparam int STRB_W           = DATA_W / 8;
    localparam int OFFSET_W         = 3;
    localparam int NUM_WAYS         = 2;
    localparam int WAY_W            = $clog2(NUM_WAYS);
    localparam int DEFAULT_SET_BITS = 6;
    localparam int TAG_W            = ADDR_W - OFFSET_W - DEFAULT_SET_BITS;

    // age counters saturate, victim ties resolve to way 0
    localparam int                AGE_W          = 3;
    localparam logic [AGE_W-1:0]  AGE_INIT       = '0;
    localparam logic [AGE_W-1:0]  AGE_MAX        = AGE_W'(7);
    localparam logic [WAY_W-1:0]  VICTIM_TIE_WAY = '0;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic              we;
    } cpu_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } cpu_resp_t;

    // wishbone classic, master side
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [STRB_W-1:0] sel;
    } wb_m2s_t;

    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
    } wb_s2m_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

endpackage
